//--- cnn_accel_pkg.sv
`default_nettype none

package cnn_accel_pkg;

  // lane geometry
  localparam int UNITS          = 4;
  localparam int WORD_WIDTH     = 8;

  // kernel length in pixel beats
  localparam int KERNEL_TAPS    = 3;
  localparam int TAP_BITS       = 2;  // holds 0 .. KERNEL_TAPS-1

  // arithmetic widths
  localparam int PROD_WIDTH     = 2 * WORD_WIDTH;
  localparam int ACC_WIDTH      = 20;  // room for the sum of KERNEL_TAPS products

  // requantization and leak
  localparam int QUANT_SHIFT    = 4;
  localparam int LEAK_SHIFT     = 3;

  // flattened buses
  localparam int LANE_BUS_WIDTH = UNITS * WORD_WIDTH;
  localparam int ACC_BUS_WIDTH  = UNITS * ACC_WIDTH;

endpackage

`default_nettype wire

//--- input_pipe.sv
`timescale 1ns/10ps
`default_nettype none

module input_pipe (
  input  wire                                           aclk,
  input  wire                                           rst_n,
  input  wire                                           s_weights_valid,
  output logic                                          s_weights_ready,
  input  wire signed [cnn_accel_pkg::WORD_WIDTH-1:0]    s_weights_data,
  input  wire                                           s_weights_last,
  input  wire                                           s_pixels_valid,
  output logic                                          s_pixels_ready,
  input  wire        [cnn_accel_pkg::LANE_BUS_WIDTH-1:0] s_pixels_data,
  input  wire                                           s_pixels_last,
  output logic                                          tap_valid,
  input  wire                                           tap_ready,
  output logic       [cnn_accel_pkg::LANE_BUS_WIDTH-1:0] tap_pixels,
  output logic signed [cnn_accel_pkg::WORD_WIDTH-1:0]   tap_weight,
  output logic                                          tap_first,
  output logic                                          tap_last,
  output logic                                          tap_frame_last
);

  import cnn_accel_pkg::*;

  localparam logic [TAP_BITS-1:0] LAST_TAP = TAP_BITS'(KERNEL_TAPS - 1);

  logic signed [WORD_WIDTH-1:0] w_mem [KERNEL_TAPS];
  logic [TAP_BITS-1:0]          w_fill;
  logic                         set_loaded;  // weights locked until frame end
  logic [TAP_BITS-1:0]          tap_cnt;
  logic                         w_accept;
  logic                         pix_accept;

  assign s_weights_ready = !set_loaded;
  assign s_pixels_ready  = set_loaded && (!tap_valid || tap_ready);

  assign w_accept   = s_weights_valid && s_weights_ready;
  assign pix_accept = s_pixels_valid && s_pixels_ready;

  // weight storage
  always_ff @(posedge aclk) begin
    if (w_accept) w_mem[w_fill] <= s_weights_data;
  end

  always_ff @(posedge aclk) begin
    if (!rst_n) begin
      w_fill     <= '0;
      set_loaded <= 1'b0;
    end else if (w_accept) begin
      if (w_fill == LAST_TAP) begin
        w_fill     <= '0;
        set_loaded <= 1'b1;
      end else begin
        w_fill <= w_fill + 1'b1;
      end
    end else if (pix_accept && s_pixels_last) begin
      set_loaded <= 1'b0;  // release for the next set
    end
  end

  // tap position within the current group
  always_ff @(posedge aclk) begin
    if (!rst_n) begin
      tap_cnt <= '0;
    end else if (pix_accept) begin
      if (tap_cnt == LAST_TAP || s_pixels_last) tap_cnt <= '0;
      else                                      tap_cnt <= tap_cnt + 1'b1;
    end
  end

  always_ff @(posedge aclk) begin
    if (!rst_n)          tap_valid <= 1'b0;
    else if (pix_accept) tap_valid <= 1'b1;
    else if (tap_ready)  tap_valid <= 1'b0;
  end

  always_ff @(posedge aclk) begin
    if (pix_accept) begin
      tap_pixels     <= s_pixels_data;
      tap_weight     <= w_mem[tap_cnt];
      tap_first      <= (tap_cnt == '0);
      tap_last       <= (tap_cnt == LAST_TAP);
      tap_frame_last <= s_pixels_last;
    end
  end

  // frame end must close a tap group
  assert property (@(posedge aclk) disable iff (!rst_n)
    pix_accept && s_pixels_last |-> tap_cnt == LAST_TAP)
    else $error("pixel last outside final tap");

  assert property (@(posedge aclk) disable iff (!rst_n)
    w_accept |-> (s_weights_last == (w_fill == LAST_TAP)))
    else $error("weight last does not match set size");

endmodule

`default_nettype wire

//--- conv_engine.sv
`timescale 1ns/10ps
`default_nettype none

module conv_engine (
  input  wire                                            aclk,
  input  wire                                            rst_n,
  input  wire                                            tap_valid,
  output logic                                           tap_ready,
  input  wire        [cnn_accel_pkg::LANE_BUS_WIDTH-1:0] tap_pixels,
  input  wire signed [cnn_accel_pkg::WORD_WIDTH-1:0]     tap_weight,
  input  wire                                            tap_first,
  input  wire                                            tap_last,
  input  wire                                            tap_frame_last,
  output logic                                           acc_valid,
  input  wire                                            acc_ready,
  output logic       [cnn_accel_pkg::ACC_BUS_WIDTH-1:0]  acc_data,
  output logic                                           acc_last
);

  import cnn_accel_pkg::*;

  // product stage
  logic signed [PROD_WIDTH-1:0] prod [UNITS];
  logic                         prod_valid;
  logic                         prod_first;
  logic                         prod_last;
  logic                         prod_frame_last;

  // accumulator stage
  logic signed [ACC_WIDTH-1:0]  acc_sum [UNITS];

  logic acc_load_ok;
  logic prod_take;
  logic tap_take;

  assign acc_load_ok = !acc_valid || acc_ready;  // finished sum not pending
  assign prod_take   = prod_valid && acc_load_ok;
  assign tap_ready   = !prod_valid || prod_take;
  assign tap_take    = tap_valid && tap_ready;

  always_ff @(posedge aclk) begin
    if (!rst_n)         prod_valid <= 1'b0;
    else if (tap_take)  prod_valid <= 1'b1;
    else if (prod_take) prod_valid <= 1'b0;
  end

  always_ff @(posedge aclk) begin
    if (tap_take) begin
      for (int u = 0; u < UNITS; u++) begin
        prod[u] <= $signed(tap_pixels[u*WORD_WIDTH +: WORD_WIDTH]) * tap_weight;
      end
      prod_first      <= tap_first;
      prod_last       <= tap_last;
      prod_frame_last <= tap_frame_last;
    end
  end

  // accumulate; only the closing tap makes the sum visible
  always_ff @(posedge aclk) begin
    if (prod_take) begin
      for (int u = 0; u < UNITS; u++) begin
        if (prod_first) acc_sum[u] <= ACC_WIDTH'(prod[u]);
        else            acc_sum[u] <= acc_sum[u] + ACC_WIDTH'(prod[u]);
      end
      acc_last <= prod_frame_last;
    end
  end

  always_ff @(posedge aclk) begin
    if (!rst_n) begin
      acc_valid <= 1'b0;
    end else if (prod_take) begin
      acc_valid <= prod_last;
    end else if (acc_ready) begin
      acc_valid <= 1'b0;
    end
  end

  for (genvar g = 0; g < UNITS; g++) begin : g_pack
    assign acc_data[g*ACC_WIDTH +: ACC_WIDTH] = acc_sum[g];
  end

  // frame end from the input pipe must sit on a closing tap
  assert property (@(posedge aclk) disable iff (!rst_n)
    tap_valid && tap_frame_last |-> tap_last)
    else $error("frame last on a tap beat without tap_last");

endmodule

`default_nettype wire

//--- lrelu_engine.sv
`timescale 1ns/10ps
`default_nettype none

module lrelu_engine (
  input  wire                                       aclk,
  input  wire                                       rst_n,
  input  wire                                       acc_valid,
  output logic                                      acc_ready,
  input  wire  [cnn_accel_pkg::ACC_BUS_WIDTH-1:0]   acc_data,
  input  wire                                       acc_last,
  output logic                                      act_valid,
  input  wire                                       act_ready,
  output logic [cnn_accel_pkg::LANE_BUS_WIDTH-1:0]  act_data,
  output logic                                      act_last
);

  import cnn_accel_pkg::*;

  logic [LANE_BUS_WIDTH-1:0] act_next;
  logic                      acc_take;

  // requantize, leak negatives, saturate to one lane word
  function automatic logic [WORD_WIDTH-1:0] activate(input logic signed [ACC_WIDTH-1:0] a);
    logic signed [ACC_WIDTH-1:0]  q;
    logic signed [ACC_WIDTH-1:0]  l;
    logic [ACC_WIDTH-WORD_WIDTH:0] hi;
    q  = a >>> QUANT_SHIFT;
    l  = q[ACC_WIDTH-1] ? (q >>> LEAK_SHIFT) : q;
    hi = l[ACC_WIDTH-1:WORD_WIDTH-1];  // all equal when it fits
    if (&hi || ~|hi) begin
      return l[WORD_WIDTH-1:0];
    end
    return l[ACC_WIDTH-1] ? {1'b1, {(WORD_WIDTH-1){1'b0}}}
                          : {1'b0, {(WORD_WIDTH-1){1'b1}}};
  endfunction

  always_comb begin
    for (int u = 0; u < UNITS; u++) begin
      act_next[u*WORD_WIDTH +: WORD_WIDTH] = activate(acc_data[u*ACC_WIDTH +: ACC_WIDTH]);
    end
  end

  assign acc_ready = !act_valid || act_ready;
  assign acc_take  = acc_valid && acc_ready;

  always_ff @(posedge aclk) begin
    if (!rst_n)         act_valid <= 1'b0;
    else if (acc_take)  act_valid <= 1'b1;
    else if (act_ready) act_valid <= 1'b0;
  end

  always_ff @(posedge aclk) begin
    if (acc_take) begin
      act_data <= act_next;
      act_last <= acc_last;
    end
  end

  assert property (@(posedge aclk) disable iff (!rst_n)
    act_valid && !act_ready |=> act_valid && $stable(act_data) && $stable(act_last))
    else $error("activation beat changed under back-pressure");

endmodule

`default_nettype wire

//--- maxpool_engine.sv
`timescale 1ns/10ps
`default_nettype none

module maxpool_engine (
  input  wire                                       aclk,
  input  wire                                       rst_n,
  input  wire                                       act_valid,
  output logic                                      act_ready,
  input  wire  [cnn_accel_pkg::LANE_BUS_WIDTH-1:0]  act_data,
  input  wire                                       act_last,
  output logic                                      m_valid,
  input  wire                                       m_ready,
  output logic [cnn_accel_pkg::LANE_BUS_WIDTH-1:0]  m_data,
  output logic                                      m_last
);

  import cnn_accel_pkg::*;

  logic                      phase;  // high while the first beat is held
  logic [LANE_BUS_WIDTH-1:0] held;
  logic [LANE_BUS_WIDTH-1:0] pool_next;
  logic                      act_take;

  // signed max per lane
  always_comb begin
    logic signed [WORD_WIDTH-1:0] a;
    logic signed [WORD_WIDTH-1:0] b;
    for (int u = 0; u < UNITS; u++) begin
      a = held[u*WORD_WIDTH +: WORD_WIDTH];
      b = act_data[u*WORD_WIDTH +: WORD_WIDTH];
      pool_next[u*WORD_WIDTH +: WORD_WIDTH] = (a > b) ? a : b;
    end
  end

  // first beat only fills the hold register
  assign act_ready = !phase || !m_valid || m_ready;
  assign act_take  = act_valid && act_ready;

  always_ff @(posedge aclk) begin
    if (!rst_n)        phase <= 1'b0;
    else if (act_take) phase <= !phase;
  end

  always_ff @(posedge aclk) begin
    if (act_take && !phase) held <= act_data;
  end

  always_ff @(posedge aclk) begin
    if (!rst_n) begin
      m_valid <= 1'b0;
    end else if (act_take && phase) begin
      m_valid <= 1'b1;
    end else if (m_ready) begin
      m_valid <= 1'b0;
    end
  end

  always_ff @(posedge aclk) begin
    if (act_take && phase) begin
      m_data <= pool_next;
      m_last <= act_last;  // second beat decides frame end
    end
  end

  assert property (@(posedge aclk) disable iff (!rst_n)
    act_take && act_last |-> phase)
    else $error("frame ended on the first beat of a pool pair");

endmodule

`default_nettype wire

//--- cnn_accel_top.sv
`timescale 1ns/10ps
`default_nettype none

module cnn_accel_top (
  input  wire                                           aclk,
  input  wire                                           rst_n,
  input  wire                                           s_weights_valid,
  output wire                                           s_weights_ready,
  input  wire signed [cnn_accel_pkg::WORD_WIDTH-1:0]    s_weights_data,
  input  wire                                           s_weights_last,
  input  wire                                           s_pixels_valid,
  output wire                                           s_pixels_ready,
  input  wire        [cnn_accel_pkg::LANE_BUS_WIDTH-1:0] s_pixels_data,
  input  wire                                           s_pixels_last,
  output wire                                           m_valid,
  input  wire                                           m_ready,
  output wire        [cnn_accel_pkg::LANE_BUS_WIDTH-1:0] m_data,
  output wire                                           m_last
);

  import cnn_accel_pkg::*;

  // tap stream
  wire                          tap_valid;
  wire                          tap_ready;
  wire [LANE_BUS_WIDTH-1:0]     tap_pixels;
  wire signed [WORD_WIDTH-1:0]  tap_weight;
  wire                          tap_first;
  wire                          tap_last;
  wire                          tap_frame_last;

  // dot products
  wire                          acc_valid;
  wire                          acc_ready;
  wire [ACC_BUS_WIDTH-1:0]      acc_data;
  wire                          acc_last;

  // activations
  wire                          act_valid;
  wire                          act_ready;
  wire [LANE_BUS_WIDTH-1:0]     act_data;
  wire                          act_last;

  input_pipe in_pipe (
    .aclk            (aclk           ),
    .rst_n           (rst_n          ),
    .s_weights_valid (s_weights_valid),
    .s_weights_ready (s_weights_ready),
    .s_weights_data  (s_weights_data ),
    .s_weights_last  (s_weights_last ),
    .s_pixels_valid  (s_pixels_valid ),
    .s_pixels_ready  (s_pixels_ready ),
    .s_pixels_data   (s_pixels_data  ),
    .s_pixels_last   (s_pixels_last  ),
    .tap_valid       (tap_valid      ),
    .tap_ready       (tap_ready      ),
    .tap_pixels      (tap_pixels     ),
    .tap_weight      (tap_weight     ),
    .tap_first       (tap_first      ),
    .tap_last        (tap_last       ),
    .tap_frame_last  (tap_frame_last )
  );

  conv_engine conv (
    .aclk           (aclk          ),
    .rst_n          (rst_n         ),
    .tap_valid      (tap_valid     ),
    .tap_ready      (tap_ready     ),
    .tap_pixels     (tap_pixels    ),
    .tap_weight     (tap_weight    ),
    .tap_first      (tap_first     ),
    .tap_last       (tap_last      ),
    .tap_frame_last (tap_frame_last),
    .acc_valid      (acc_valid     ),
    .acc_ready      (acc_ready     ),
    .acc_data       (acc_data      ),  // lane 0 in the low bits
    .acc_last       (acc_last      )
  );

  lrelu_engine lrelu (
    .aclk      (aclk     ),
    .rst_n     (rst_n    ),
    .acc_valid (acc_valid),
    .acc_ready (acc_ready),
    .acc_data  (acc_data ),
    .acc_last  (acc_last ),
    .act_valid (act_valid),
    .act_ready (act_ready),
    .act_data  (act_data ),
    .act_last  (act_last )
  );

  maxpool_engine maxpool (
    .aclk      (aclk     ),
    .rst_n     (rst_n    ),
    .act_valid (act_valid),
    .act_ready (act_ready),
    .act_data  (act_data ),
    .act_last  (act_last ),
    .m_valid   (m_valid  ),
    .m_ready   (m_ready  ),
    .m_data    (m_data   ),
    .m_last    (m_last   )
  );

endmodule

`default_nettype wire

//--- tb_cnn_accel.sv
`timescale 1ns/10ps
`default_nettype none

module tb_cnn_accel;

  import cnn_accel_pkg::*;

  localparam int NROWS   = 5;
  localparam int TIMEOUT = 200;  // cycles per wait loop

  logic                                  aclk;
  logic                                  rst_n;
  logic                                  s_weights_valid;
  wire                                   s_weights_ready;
  logic signed [WORD_WIDTH-1:0]          s_weights_data;
  logic                                  s_weights_last;
  logic                                  s_pixels_valid;
  wire                                   s_pixels_ready;
  logic [LANE_BUS_WIDTH-1:0]             s_pixels_data;
  logic                                  s_pixels_last;
  wire                                   m_valid;
  logic                                  m_ready;
  wire  [LANE_BUS_WIDTH-1:0]             m_data;
  wire                                   m_last;

  // one row per frame
  logic [KERNEL_TAPS*WORD_WIDTH-1:0] row_weights [NROWS];  // tap 0 in the low byte
  int                                row_groups [NROWS];
  logic                              row_rand_pix [NROWS];
  logic [LANE_BUS_WIDTH-1:0]         row_pix [NROWS];  // used when not random
  logic                              row_gated [NROWS];

  logic [LANE_BUS_WIDTH-1:0] beats [$];
  logic [LANE_BUS_WIDTH-1:0] exp_data [$];
  logic                      exp_last [$];
  logic [31:0]               lfsr;

  cnn_accel_top uut (
    .aclk            (aclk           ),
    .rst_n           (rst_n          ),
    .s_weights_valid (s_weights_valid),
    .s_weights_ready (s_weights_ready),
    .s_weights_data  (s_weights_data ),
    .s_weights_last  (s_weights_last ),
    .s_pixels_valid  (s_pixels_valid ),
    .s_pixels_ready  (s_pixels_ready ),
    .s_pixels_data   (s_pixels_data  ),
    .s_pixels_last   (s_pixels_last  ),
    .m_valid         (m_valid        ),
    .m_ready         (m_ready        ),
    .m_data          (m_data         ),
    .m_last          (m_last         )
  );

  initial begin
    aclk = 1'b0;
    forever #2 aclk = ~aclk;
  end

  task automatic set_row(input int r, input logic [KERNEL_TAPS*WORD_WIDTH-1:0] w,
                         input int groups, input logic rand_pix,
                         input logic [LANE_BUS_WIDTH-1:0] pix, input logic gated);
    row_weights[r]  = w;
    row_groups[r]   = groups;
    row_rand_pix[r] = rand_pix;
    row_pix[r]      = pix;
    row_gated[r]    = gated;
  endtask

  task automatic fill_table;
    set_row(0, 24'h030201, 2, 1'b0, 32'h281e140a, 1'b0);  // lanes 10 20 30 40
    set_row(1, 24'h7f7f7f, 2, 1'b0, 32'h02f67f80, 1'b0);  // -128 127 -10 2
    set_row(2, 24'h03f905, 4, 1'b1, '0, 1'b0);
    set_row(3, 24'h090dec, 6, 1'b1, '0, 1'b1);
    set_row(4, 24'h20c040, 4, 1'b1, '0, 1'b1);
  endtask

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic next_bit();
    lfsr = lfsr_step(lfsr);
    return lfsr[0];
  endfunction

  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r = {r[30:0], next_bit()};
    end
    return r;
  endfunction

  function automatic int lane_of(input logic [LANE_BUS_WIDTH-1:0] beat, input int l);
    logic signed [WORD_WIDTH-1:0] v;
    v = beat[l*WORD_WIDTH +: WORD_WIDTH];
    return v;
  endfunction

  function automatic int weight_of(input logic [KERNEL_TAPS*WORD_WIDTH-1:0] set, input int t);
    logic signed [WORD_WIDTH-1:0] v;
    v = set[t*WORD_WIDTH +: WORD_WIDTH];
    return v;
  endfunction

  // requantize, leak, clip
  function automatic int activate_ref(input int acc);
    int q;
    q = acc >>> QUANT_SHIFT;
    if (q < 0) q = q >>> LEAK_SHIFT;
    if (q > 127) q = 127;
    if (q < -128) q = -128;
    return q;
  endfunction

  task automatic stop_run;
    $display("FAIL: see errors above");
    $fatal(1, "stopped at first error");
  endtask

  task automatic flag_mismatch(input string msg);
    $display("[FAIL] %0t ns: %s", $time, msg);
    stop_run();
  endtask

  // pixels for one row and the pooled results they should give
  task automatic build_row(input int r);
    int                        n_beats;
    int                        acc;
    int                        mx;
    int                        act [16][UNITS];
    logic [LANE_BUS_WIDTH-1:0] word;
    beats.delete();
    exp_data.delete();
    exp_last.delete();
    n_beats = row_groups[r] * KERNEL_TAPS;
    for (int b = 0; b < n_beats; b++) begin
      beats.push_back(row_rand_pix[r] ? take_bits(LANE_BUS_WIDTH) : row_pix[r]);
    end
    for (int g = 0; g < row_groups[r]; g++) begin
      for (int l = 0; l < UNITS; l++) begin
        acc = 0;
        for (int t = 0; t < KERNEL_TAPS; t++) begin
          acc += lane_of(beats[g*KERNEL_TAPS+t], l) * weight_of(row_weights[r], t);
        end
        act[g][l] = activate_ref(acc);
      end
    end
    for (int k = 0; k < row_groups[r] / 2; k++) begin
      word = '0;
      for (int l = 0; l < UNITS; l++) begin
        mx = (act[2*k][l] > act[2*k+1][l]) ? act[2*k][l] : act[2*k+1][l];
        word[l*WORD_WIDTH +: WORD_WIDTH] = mx[WORD_WIDTH-1:0];
      end
      exp_data.push_back(word);
      exp_last.push_back(k == row_groups[r] / 2 - 1);
    end
  endtask

  task automatic send_weights(input logic [KERNEL_TAPS*WORD_WIDTH-1:0] set);
    int cnt;
    for (int t = 0; t < KERNEL_TAPS; t++) begin
      s_weights_valid = 1'b1;
      s_weights_data  = set[t*WORD_WIDTH +: WORD_WIDTH];
      s_weights_last  = (t == KERNEL_TAPS - 1);
      cnt = 0;
      @(negedge aclk);
      while (!s_weights_ready) begin
        cnt++;
        if (cnt > TIMEOUT) begin
          $display("timeout: weight %0d was never accepted", t);
          stop_run();
        end
        @(negedge aclk);
      end
      assert (!s_pixels_ready)
        else flag_mismatch("pixel stream open before the weight set was complete");
      @(posedge aclk);
      #1;
    end
    s_weights_valid = 1'b0;
    s_weights_last  = 1'b0;
  endtask

  task automatic send_pixels;
    int cnt;
    for (int b = 0; b < beats.size(); b++) begin
      s_pixels_valid = 1'b1;
      s_pixels_data  = beats[b];
      s_pixels_last  = (b == beats.size() - 1);
      cnt = 0;
      @(negedge aclk);
      while (!s_pixels_ready) begin
        cnt++;
        if (cnt > TIMEOUT) begin
          $display("timeout: pixel beat %0d was never accepted", b);
          stop_run();
        end
        @(negedge aclk);
      end
      @(posedge aclk);
      #1;
    end
    s_pixels_valid = 1'b0;
    s_pixels_last  = 1'b0;
    @(negedge aclk);
    assert (s_weights_ready && !s_pixels_ready)
      else flag_mismatch("weight set not released after frame end");
  endtask

  task automatic collect_outputs(input logic gated);
    int                        idx;
    int                        idle;
    logic                      stalled;
    logic [LANE_BUS_WIDTH-1:0] held;
    idx     = 0;
    idle    = 0;
    stalled = 1'b0;
    while (idx < exp_data.size()) begin
      @(posedge aclk);
      #1;
      m_ready = gated ? next_bit() : 1'b1;
      @(negedge aclk);
      if (stalled) begin
        assert (m_valid && m_data == held)
          else flag_mismatch($sformatf("m_data moved while stalled: %h, held %h",
                                       m_data, held));
      end
      if (m_valid && m_ready) begin
        assert (m_data == exp_data[idx] && m_last == exp_last[idx])
          else flag_mismatch($sformatf("output %0d: got %h last %b, expected %h last %b",
                                       idx, m_data, m_last, exp_data[idx], exp_last[idx]));
        idx++;
        idle    = 0;
        stalled = 1'b0;
      end else begin
        idle++;
        if (idle > TIMEOUT) begin
          $display("timeout: output %0d never arrived", idx);
          stop_run();
        end
        stalled = m_valid;
        held    = m_data;
      end
    end
  endtask

  initial begin
    s_weights_valid = 1'b0;
    s_weights_data  = '0;
    s_weights_last  = 1'b0;
    s_pixels_valid  = 1'b0;
    s_pixels_data   = '0;
    s_pixels_last   = 1'b0;
    m_ready         = 1'b0;
    rst_n           = 1'b0;
    lfsr            = 32'h7e6bb2ca;
    fill_table();

    repeat (2) @(posedge aclk);
    #1 rst_n = 1'b1;
    @(negedge aclk);
    assert (!m_valid && s_weights_ready && !s_pixels_ready)
      else flag_mismatch("wrong stream state after reset");

    for (int r = 0; r < NROWS; r++) begin
      build_row(r);
      @(posedge aclk);
      #1;
      assert (s_weights_ready && !s_pixels_ready && !m_valid)
        else flag_mismatch($sformatf("row %0d: DUT not idle at frame start", r));
      fork
        send_weights(row_weights[r]);
        send_pixels();
        collect_outputs(row_gated[r]);
      join
    end

    @(posedge aclk);
    #1;
    assert (!m_valid)
      else flag_mismatch("extra output after the last frame");

    $display("PASS: all tests");
    $finish;
  end

endmodule

`default_nettype wire

//--- cnn_accel.f
cnn_accel_pkg.sv
input_pipe.sv
conv_engine.sv
lrelu_engine.sv
maxpool_engine.sv
cnn_accel_top.sv
tb_cnn_accel.sv
